/* radio_regs_pkg.sv */
package radio_regs_pkg;

// Host port widths
localparam int REG_ADDR_W  = 7;
localparam int REG_DATA_W  = 32;
localparam int IRQ_FIELD_W = 8; // One byte per IRQ field

// Register map
localparam logic [REG_ADDR_W-1:0] REG_ID               = 7'h00;
localparam logic [REG_ADDR_W-1:0] REG_IRQ_CNTRL_STATUS = 7'h02;
localparam logic [REG_ADDR_W-1:0] REG_LED_CNTRL        = 7'h10;
localparam logic [REG_ADDR_W-1:0] REG_RED_LED_DUTY     = 7'h11;
localparam logic [REG_ADDR_W-1:0] REG_GREEN_LED_DUTY   = 7'h12;
localparam logic [REG_ADDR_W-1:0] REG_BLUE_LED_DUTY    = 7'h13;
localparam logic [REG_ADDR_W-1:0] REG_ADC_BUF_CNTRL    = 7'h20;
localparam logic [REG_ADDR_W-1:0] REG_ADC_BUF_ADDR     = 7'h21;
localparam logic [REG_ADDR_W-1:0] REG_ADC_BUF_DATA     = 7'h22;

localparam logic [REG_DATA_W-1:0] DEVICE_ID = 32'hDADC0001;

// Host request, held stable until ack falls
typedef struct packed {
    logic                  req;
    logic                  wr;    // 1 for write, 0 for read
    logic [REG_ADDR_W-1:0] addr;
    logic [REG_DATA_W-1:0] wdata;
} host_req_t;

typedef struct packed {
    logic                  ack;
    logic [REG_DATA_W-1:0] rdata;
} host_rsp_t;

// IRQ word as the host writes it
typedef struct packed {
    logic [IRQ_FIELD_W-1:0] set;
    logic [IRQ_FIELD_W-1:0] clear;
    logic [IRQ_FIELD_W-1:0] dsp_mask;
    logic [IRQ_FIELD_W-1:0] smc_mask;
} irq_wr_view_t;

// IRQ word as the host reads it back
typedef struct packed {
    logic [IRQ_FIELD_W-1:0] zero;
    logic [IRQ_FIELD_W-1:0] pending;
    logic [IRQ_FIELD_W-1:0] dsp_mask;
    logic [IRQ_FIELD_W-1:0] smc_mask;
} irq_rd_view_t;

typedef union packed {
    irq_wr_view_t wr;
    irq_rd_view_t rd;
} irq_word_u;

endpackage

/* radio_periph_pkg.sv */
package radio_periph_pkg;

// Interrupt controller
localparam int IRQ_COUNT          = 8;
localparam int IRQ_CAPTURE_ACTIVE = 0; // High while the buffer fills
localparam int IRQ_CAPTURE_DONE   = 1;

// LED PWM
localparam int LED_COUNT = 3;
localparam int LED_PWM_W = 12;
localparam int LED_RED   = 0;
localparam int LED_GREEN = 1;
localparam int LED_BLUE  = 2;

// ADC capture buffer
localparam int ADC_DATA_W     = 16;
localparam int ADC_BUF_ADDR_W = 12;
localparam int ADC_BUF_DEPTH  = 1 << ADC_BUF_ADDR_W; // 4K samples

// One ADC sample with its overflow flag on top
typedef struct packed {
    logic                  ovf;
    logic [ADC_DATA_W-1:0] data;
} adc_sample_t;

// LED settings, all levels
typedef struct packed {
    logic                                enable;
    logic [LED_COUNT-1:0][LED_PWM_W-1:0] duty;
} led_cfg_t;

// Masks are levels, set and clear are single-cycle pulses
typedef struct packed {
    logic [IRQ_COUNT-1:0] set;
    logic [IRQ_COUNT-1:0] clear;
    logic [IRQ_COUNT-1:0] dsp_mask;
    logic [IRQ_COUNT-1:0] smc_mask;
} irq_cmd_t;

endpackage

/* radio_ctrl_regs.sv */
`timescale 1ns/10ps

module radio_ctrl_regs
    import radio_regs_pkg::*;
    import radio_periph_pkg::*;
(
    input  logic                      led_clk,
    input  logic                      adc_dpram_rst,
    input  host_req_t                 host_req,
    output host_rsp_t                 host_rsp,
    output led_cfg_t                  led_cfg,
    output irq_cmd_t                  irq_cmd,
    output logic                      capture_trig,
    output logic [ADC_BUF_ADDR_W-1:0] buf_rd_addr,
    input  logic                      capture_busy,
    input  adc_sample_t               buf_rd_data,
    input  logic [IRQ_COUNT-1:0]      irq_pending
);

logic                  ack_q;
logic [REG_DATA_W-1:0] rdata_q;
logic                  access;   // New request this cycle
logic                  auto_inc; // Data reads advance the read address
logic [REG_DATA_W-1:0] rd_word;
irq_word_u             irq_wr;
irq_word_u             irq_rd;

assign access = host_req.req && !ack_q;
assign irq_wr = host_req.wdata;

assign host_rsp = '{ack: ack_q, rdata: rdata_q};

// Four-phase handshake
always_ff @(posedge led_clk)
    begin
        if(adc_dpram_rst)
            ack_q <= 1'b0;
        else if(access)
            ack_q <= 1'b1;
        else if(!host_req.req)
            ack_q <= 1'b0; // Host has let go
    end

// Read data is latched on the access edge
always_ff @(posedge led_clk)
    begin
        if(access && !host_req.wr)
            rdata_q <= rd_word;
    end

// Register storage and write pulses
always_ff @(posedge led_clk)
    begin
        if(adc_dpram_rst)
            begin
                led_cfg <= '0;
                irq_cmd <= '0;
                capture_trig <= 1'b0;
                auto_inc <= 1'b0;
                buf_rd_addr <= '0;
            end
        else
            begin
                irq_cmd.set <= '0;
                irq_cmd.clear <= '0;
                capture_trig <= 1'b0;

                if(access && host_req.wr)
                    begin
                        case(host_req.addr)
                            REG_IRQ_CNTRL_STATUS:
                                begin
                                    irq_cmd.smc_mask <= irq_wr.wr.smc_mask;
                                    irq_cmd.dsp_mask <= irq_wr.wr.dsp_mask;
                                    irq_cmd.clear <= irq_wr.wr.clear;
                                    irq_cmd.set <= irq_wr.wr.set;
                                end
                            REG_LED_CNTRL:
                                led_cfg.enable <= host_req.wdata[0];
                            REG_RED_LED_DUTY:
                                led_cfg.duty[LED_RED] <= host_req.wdata[LED_PWM_W-1:0];
                            REG_GREEN_LED_DUTY:
                                led_cfg.duty[LED_GREEN] <= host_req.wdata[LED_PWM_W-1:0];
                            REG_BLUE_LED_DUTY:
                                led_cfg.duty[LED_BLUE] <= host_req.wdata[LED_PWM_W-1:0];
                            REG_ADC_BUF_CNTRL:
                                begin
                                    capture_trig <= host_req.wdata[0]; // Ignored by the buffer if busy
                                    auto_inc <= host_req.wdata[1];
                                end
                            REG_ADC_BUF_ADDR:
                                buf_rd_addr <= host_req.wdata[ADC_BUF_ADDR_W-1:0];
                            default:
                                ;
                        endcase
                    end

                // Step to the next sample after each data read
                if(access && !host_req.wr && host_req.addr == REG_ADC_BUF_DATA && auto_inc)
                    buf_rd_addr <= buf_rd_addr + 1'b1;
            end
    end

// IRQ status word as seen by the host
always_comb
    begin
        irq_rd.rd.zero = '0;
        irq_rd.rd.pending = irq_pending;
        irq_rd.rd.dsp_mask = irq_cmd.dsp_mask;
        irq_rd.rd.smc_mask = irq_cmd.smc_mask;
    end

// Read mux, unmapped addresses return zero
always_comb
    begin
        case(host_req.addr)
            REG_ID:
                rd_word = DEVICE_ID;
            REG_IRQ_CNTRL_STATUS:
                rd_word = irq_rd;
            REG_LED_CNTRL:
                rd_word = REG_DATA_W'(led_cfg.enable);
            REG_RED_LED_DUTY:
                rd_word = REG_DATA_W'(led_cfg.duty[LED_RED]);
            REG_GREEN_LED_DUTY:
                rd_word = REG_DATA_W'(led_cfg.duty[LED_GREEN]);
            REG_BLUE_LED_DUTY:
                rd_word = REG_DATA_W'(led_cfg.duty[LED_BLUE]);
            REG_ADC_BUF_CNTRL:
                rd_word = REG_DATA_W'({capture_busy, auto_inc, 1'b0}); // Trigger is write only
            REG_ADC_BUF_ADDR:
                rd_word = REG_DATA_W'(buf_rd_addr);
            REG_ADC_BUF_DATA:
                rd_word = REG_DATA_W'(buf_rd_data); // Overflow lands in bit 16
            default:
                rd_word = '0;
        endcase
    end

endmodule

/* adc_capture_buf.sv */
`timescale 1ns/10ps

module adc_capture_buf import radio_periph_pkg::*;
(
    input  logic                      led_clk,
    input  logic                      adc_dpram_rst,
    input  adc_sample_t               adc_in,
    input  logic                      capture_trig,
    input  logic [ADC_BUF_ADDR_W-1:0] buf_rd_addr,
    output adc_sample_t               buf_rd_data,
    output logic                      capture_busy
);

adc_sample_t               adc_q;   // ADC pins, one cycle late
logic [ADC_BUF_ADDR_W-1:0] wr_addr;
adc_sample_t               mem [0:ADC_BUF_DEPTH-1];

always_ff @(posedge led_clk)
    begin
        adc_q <= adc_in;
    end

// Capture sequencer, one full pass per trigger
always_ff @(posedge led_clk)
    begin
        if(adc_dpram_rst)
            begin
                capture_busy <= 1'b0;
                wr_addr <= '0;
            end
        else if(!capture_busy)
            begin
                wr_addr <= '0;

                if(capture_trig)
                    capture_busy <= 1'b1;
            end
        else
            begin
                if(wr_addr == '1)
                    capture_busy <= 1'b0; // Last address written

                wr_addr <= wr_addr + 1'b1;
            end
    end

// Write port
always_ff @(posedge led_clk)
    begin
        if(capture_busy)
            mem[wr_addr] <= adc_q;
    end

// Read port, free of the write side
assign buf_rd_data = mem[buf_rd_addr];

endmodule

/* irq_ctrl.sv */
`timescale 1ns/10ps

module irq_ctrl import radio_periph_pkg::*;
(
    input  logic                 led_clk,
    input  logic                 adc_dpram_rst,
    input  logic [IRQ_COUNT-1:0] irq_lines,
    input  irq_cmd_t             irq_cmd,
    output logic [IRQ_COUNT-1:0] irq_pending,
    output logic                 smc_irq_n,
    output logic                 dsp_irq_n
);

logic [IRQ_COUNT-1:0] lines_q; // Line levels a cycle back
logic [IRQ_COUNT-1:0] rise;

assign rise = irq_lines & ~lines_q;

always_ff @(posedge led_clk)
    begin
        lines_q <= irq_lines;
    end

// Pending bits, set beats clear
always_ff @(posedge led_clk)
    begin
        if(adc_dpram_rst)
            irq_pending <= '0;
        else
            irq_pending <= (irq_pending & ~irq_cmd.clear) | irq_cmd.set | rise;
    end

// Active low while any unmasked line is pending
assign smc_irq_n = ~|(irq_pending & irq_cmd.smc_mask);
assign dsp_irq_n = ~|(irq_pending & irq_cmd.dsp_mask);

endmodule

/* led_pwm.sv */
`timescale 1ns/10ps

module led_pwm import radio_periph_pkg::*;
(
    input  logic     led_clk,
    input  logic     adc_dpram_rst,
    input  led_cfg_t led_cfg,
    output logic     red_led,
    output logic     green_led,
    output logic     blue_led
);

logic [LED_PWM_W-1:0] pwm_cnt; // Shared by all channels
logic [LED_COUNT-1:0] led_q;

always_ff @(posedge led_clk)
    begin
        if(adc_dpram_rst || !led_cfg.enable)
            pwm_cnt <= '0;
        else
            pwm_cnt <= pwm_cnt + 1'b1; // Wraps every 4096 cycles
    end

for(genvar i = 0; i < LED_COUNT; i++)
    begin : g_chan
        always_ff @(posedge led_clk)
            begin
                if(adc_dpram_rst || !led_cfg.enable || led_cfg.duty[i] == '0)
                    led_q[i] <= 1'b0;
                else if(pwm_cnt == '0)
                    led_q[i] <= 1'b1; // Start of period
                else if(pwm_cnt == led_cfg.duty[i])
                    led_q[i] <= 1'b0;
            end
    end

assign red_led   = led_q[LED_RED];
assign green_led = led_q[LED_GREEN];
assign blue_led  = led_q[LED_BLUE];

endmodule

/* radio_core.sv */
`timescale 1ns/10ps

module radio_core
    import radio_regs_pkg::*;
    import radio_periph_pkg::*;
(
    input  logic        led_clk,
    input  logic        adc_dpram_rst,
    input  host_req_t   host_req,
    output host_rsp_t   host_rsp,
    input  adc_sample_t adc_in,
    output logic        red_led,
    output logic        green_led,
    output logic        blue_led,
    output logic        smc_irq_n,
    output logic        dsp_irq_n
);

led_cfg_t                  led_cfg;
irq_cmd_t                  irq_cmd;
logic                      capture_trig;
logic                      capture_busy;
logic [ADC_BUF_ADDR_W-1:0] buf_rd_addr;
adc_sample_t               buf_rd_data;
logic [IRQ_COUNT-1:0]      irq_lines;
logic [IRQ_COUNT-1:0]      irq_pending;

// IRQ line sources
assign irq_lines[IRQ_CAPTURE_ACTIVE] = capture_busy;
assign irq_lines[IRQ_CAPTURE_DONE]   = ~capture_busy;
assign irq_lines[IRQ_COUNT-1:IRQ_CAPTURE_DONE+1] = '0; // Software set only

radio_ctrl_regs u_regs
(
    .led_clk(led_clk),
    .adc_dpram_rst(adc_dpram_rst),
    .host_req(host_req),
    .host_rsp(host_rsp),
    .led_cfg(led_cfg),
    .irq_cmd(irq_cmd),
    .capture_trig(capture_trig),
    .buf_rd_addr(buf_rd_addr),
    .capture_busy(capture_busy),
    .buf_rd_data(buf_rd_data),
    .irq_pending(irq_pending)
);

adc_capture_buf u_adc_buf
(
    .led_clk(led_clk),
    .adc_dpram_rst(adc_dpram_rst),
    .adc_in(adc_in),
    .capture_trig(capture_trig),
    .buf_rd_addr(buf_rd_addr),
    .buf_rd_data(buf_rd_data),
    .capture_busy(capture_busy)
);

irq_ctrl u_irq
(
    .led_clk(led_clk),
    .adc_dpram_rst(adc_dpram_rst),
    .irq_lines(irq_lines),
    .irq_cmd(irq_cmd),
    .irq_pending(irq_pending),
    .smc_irq_n(smc_irq_n),
    .dsp_irq_n(dsp_irq_n)
);

led_pwm u_led
(
    .led_clk(led_clk),
    .adc_dpram_rst(adc_dpram_rst),
    .led_cfg(led_cfg),
    .red_led(red_led),
    .green_led(green_led),
    .blue_led(blue_led)
);

endmodule

/* radio_core_props.sv */
`timescale 1ns/10ps

module radio_core_props import radio_regs_pkg::*;
(
    input logic      led_clk,
    input logic      adc_dpram_rst,
    input host_req_t host_req,
    input host_rsp_t host_rsp,
    input logic      smc_irq_n,
    input logic      dsp_irq_n
);

int violations = 0; // Failed assertions so far

// ack only answers a request seen on the previous edge
ack_needs_req: assert property (@(posedge led_clk) disable iff (adc_dpram_rst)
    $rose(host_rsp.ack) |-> $past(host_req.req))
    else
        begin
            $error("ack rose with no request pending");
            violations++;
        end

// Host must have let go before ack drops
ack_holds_for_req: assert property (@(posedge led_clk) disable iff (adc_dpram_rst)
    $fell(host_rsp.ack) |-> !$past(host_req.req))
    else
        begin
            $error("ack fell while req was still high");
            violations++;
        end

irq_idle_in_reset: assert property (@(posedge led_clk)
    adc_dpram_rst ##1 adc_dpram_rst |-> smc_irq_n && dsp_irq_n)
    else
        begin
            $error("IRQ output low during reset");
            violations++;
        end

endmodule

/* radio_checker.sv */
`timescale 1ns/10ps

module radio_checker
    import radio_regs_pkg::*;
    import radio_periph_pkg::*;
(
    input  logic      led_clk,
    input  host_rsp_t host_rsp,
    input  logic      red_led,
    input  logic      green_led,
    input  logic      blue_led,
    input  logic      smc_irq_n,
    input  logic      dsp_irq_n,
    output int        pass_cnt,
    output int        fail_cnt
);

logic ack_q;
int   ack_rises; // Handshakes seen on the port

initial
    begin
        pass_cnt = 0;
        fail_cnt = 0;
        ack_rises = 0;
        ack_q = 1'b0;
    end

always @(posedge led_clk)
    begin
        if (host_rsp.ack === 1'b1 && ack_q === 1'b0)
            ack_rises++;
        ack_q <= host_rsp.ack;
    end

task automatic record_result(input string name, input logic ok,
                             input logic [31:0] exp, input logic [31:0] act);
    if (ok)
        begin
            pass_cnt++;
            $display("PASS     %s", name);
        end
    else
        begin
            fail_cnt++;
            $display("MISMATCH %s expected %h actual %h", name, exp, act);
        end
endtask

task automatic verify_rdata(input string name, input logic [31:0] exp);
    record_result(name, host_rsp.rdata === exp, exp, host_rsp.rdata);
endtask

// High cycles of one LED over a full PWM period
task automatic count_led_high(input string name, input int idx, input logic [31:0] exp);
    int         high;
    logic [2:0] leds;
    high = 0;
    repeat (1 << LED_PWM_W)
        begin
            @(posedge led_clk);
            #1;
            leds = {blue_led, green_led, red_led};
            high += (leds[idx] === 1'b1);
        end
    record_result(name, high == exp, exp, high);
endtask

task automatic sample_irq_pins(input string name, input logic [1:0] exp);
    record_result(name, {smc_irq_n, dsp_irq_n} === exp, exp, {smc_irq_n, dsp_irq_n});
endtask

task automatic tally_acks(input string name, input int exp);
    record_result(name, ack_rises == exp, exp, ack_rises);
endtask

task automatic note_failure(input string name, input string what);
    fail_cnt++;
    $display("ERROR: %s %s", name, what);
endtask

task automatic print_summary();
    $display("Summary: %0d passed, %0d failed", pass_cnt, fail_cnt);
endtask

endmodule

/* tb_radio_core.sv */
`timescale 1ns/10ps

module tb_radio_core
    import radio_regs_pkg::*;
    import radio_periph_pkg::*;
();

logic        led_clk;
logic        adc_dpram_rst;
host_req_t   host_req;
host_rsp_t   host_rsp;
adc_sample_t adc_in;
adc_sample_t capt_sample; // Held on the pins during the last capture
logic        red_led;
logic        green_led;
logic        blue_led;
logic        smc_irq_n;
logic        dsp_irq_n;
logic        timed_out;
logic        bad_vector;
int          xfer_cnt;    // Completed host transactions
int          pass_cnt;
int          fail_cnt;

initial
    led_clk = 1'b0;

always #4 led_clk = ~led_clk;

radio_core uut
(
    .led_clk(led_clk),
    .adc_dpram_rst(adc_dpram_rst),
    .host_req(host_req),
    .host_rsp(host_rsp),
    .adc_in(adc_in),
    .red_led(red_led),
    .green_led(green_led),
    .blue_led(blue_led),
    .smc_irq_n(smc_irq_n),
    .dsp_irq_n(dsp_irq_n)
);

radio_checker chk
(
    .led_clk(led_clk),
    .host_rsp(host_rsp),
    .red_led(red_led),
    .green_led(green_led),
    .blue_led(blue_led),
    .smc_irq_n(smc_irq_n),
    .dsp_irq_n(dsp_irq_n),
    .pass_cnt(pass_cnt),
    .fail_cnt(fail_cnt)
);

bind radio_core radio_core_props u_props (.*);

// One four-phase transaction, entered 1 ns after a rising edge
task automatic host_access(input logic wr, input logic [REG_ADDR_W-1:0] addr,
                           input logic [REG_DATA_W-1:0] wdata);
    int waited;
    host_req = '{req: 1'b1, wr: wr, addr: addr, wdata: wdata};
    waited = 0;
    while (host_rsp.ack !== 1'b1 && waited < 16)
        begin
            @(posedge led_clk);
            #1;
            waited++;
        end
    host_req.req = 1'b0;
    if (host_rsp.ack !== 1'b1)
        begin
            $display("ERROR: no ack for access to address %h", addr);
            timed_out = 1'b1;
        end
    else
        begin
            waited = 0;
            while (host_rsp.ack !== 1'b0 && waited < 16)
                begin
                    @(posedge led_clk);
                    #1;
                    waited++;
                end
            if (host_rsp.ack !== 1'b0)
                begin
                    $display("ERROR: ack stuck high after req dropped, address %h", addr);
                    timed_out = 1'b1;
                end
            else
                xfer_cnt++;
        end
endtask

task automatic run_capture(input string name, input logic [31:0] wdata,
                           input logic [31:0] exp);
    int   polls;
    logic seen_busy;
    capt_sample = adc_in; // Pins stay put until the buffer is full
    seen_busy = 1'b0;
    polls = 0;
    host_access(1'b1, REG_ADC_BUF_CNTRL, wdata);
    host_access(1'b0, REG_ADC_BUF_CNTRL, '0);
    while (!timed_out && host_rsp.rdata[2] && polls < ADC_BUF_DEPTH) // Busy bit
        begin
            seen_busy = 1'b1;
            host_access(1'b0, REG_ADC_BUF_CNTRL, '0);
            polls++;
        end
    if (!timed_out && host_rsp.rdata[2])
        begin
            $display("ERROR: capture %s still busy after %0d polls", name, polls);
            timed_out = 1'b1;
        end
    else if (!timed_out && !seen_busy)
        chk.note_failure(name, "busy bit never set after the trigger");
    else if (!timed_out)
        chk.verify_rdata(name, exp);
endtask

task automatic apply_vector(input byte op, input string name, input logic [31:0] addr,
                            input logic [31:0] data, input logic [31:0] exp);
    adc_in = 17'($urandom); // New ADC value for every test
    case (op)
        "W":
            host_access(1'b1, addr[REG_ADDR_W-1:0], data);
        "R", "D":
            begin
                host_access(1'b0, addr[REG_ADDR_W-1:0], '0);
                if (!timed_out && op == "R")
                    chk.verify_rdata(name, exp);
                else if (!timed_out)
                    chk.verify_rdata(name, 32'(capt_sample)); // Overflow in bit 16
            end
        "C":
            run_capture(name, data, exp);
        "L":
            chk.count_led_high(name, int'(addr), exp);
        "I":
            chk.sample_irq_pins(name, exp[1:0]);
        "H":
            chk.tally_acks(name, xfer_cnt);
        default:
            begin
                $display("ERROR: unknown command in vector for test %s", name);
                bad_vector = 1'b1;
            end
    endcase
endtask

initial
    begin
        int          fd;
        int          fields;
        string       line;
        string       cmd;
        string       name;
        logic [31:0] addr;
        logic [31:0] data;
        logic [31:0] exp;
        void'($urandom(32'h715a_9feb));
        host_req = '0;
        adc_in = '0;
        adc_dpram_rst = 1'b1;
        timed_out = 1'b0;
        bad_vector = 1'b0;
        xfer_cnt = 0;
        repeat (10) @(posedge led_clk);
        #1;
        adc_dpram_rst = 1'b0;

        fd = $fopen("radio_vectors.txt", "r");
        if (fd == 0)
            begin
                $display("ERROR: cannot open radio_vectors.txt");
                bad_vector = 1'b1;
            end
        else
            begin
                while (!timed_out && !$feof(fd))
                    begin
                        line = "";
                        if ($fgets(line, fd) != 0 && line.len() > 1 && line.getc(0) != "#")
                            begin
                                fields = $sscanf(line, "%s %s %h %h %h",
                                                 cmd, name, addr, data, exp);
                                if (fields == 5)
                                    apply_vector(cmd.getc(0), name, addr, data, exp);
                                else
                                    begin
                                        $display("ERROR: malformed vector line: %s", line);
                                        bad_vector = 1'b1;
                                    end
                            end
                    end
                $fclose(fd);
            end

        chk.print_summary();
        if (timed_out || bad_vector || fail_cnt != 0 || uut.u_props.violations != 0)
            $display("Verification failed");
        else
            $display("Verification passed");
        $finish;
    end

endmodule

/* radio_vectors.txt */
# cmd name addr data expect, hex. W write, R read, C capture, D sample read,
# L LED high cycles in one period (addr is the LED), I {smc_irq_n,dsp_irq_n}, H acks
R id_reg 00 00000000 dadc0001
R unmapped_05 05 00000000 00000000
R unmapped_7f 7f 00000000 00000000
W irq_masks 02 00ff3ca4 00000000
R irq_readback 02 00000000 00003ca4
W red_duty_wr 11 fffff123 00000000
W green_duty_wr 12 00000800 00000000
W blue_duty_wr 13 00000000 00000000
R red_duty 11 00000000 00000123
W led_on 10 ffffffff 00000000
R led_cntrl 10 00000000 00000001
L red_pwm 00 00000000 00000123
L green_pwm 01 00000000 00000800
L blue_pwm 02 00000000 00000000
W led_off 10 00000000 00000000
L red_disabled 00 00000000 00000000
I irq_idle 00 00000000 00000003
C capture 20 00000003 00000002
W rd_addr_wr 21 00000010 00000000
D sample_0 22 00000000 00000000
D sample_1 22 00000000 00000000
D sample_2 22 00000000 00000000
R rd_addr_adv 21 00000000 00000013
R irq_after_capture 02 00000000 00033ca4
I irq_masked_off 00 00000000 00000003
W smc_mask_line0 02 00003c01 00000000
I smc_asserted 00 00000000 00000001
W clear_capture 02 00033c01 00000000
I smc_released 00 00000000 00000003
R irq_cleared 02 00000000 00003c01
W set_line5 02 20002000 00000000
I dsp_asserted 00 00000000 00000002
R irq_set_line5 02 00000000 00202000
H ack_count 00 00000000 00000000

/* project.f */
radio_regs_pkg.sv
radio_periph_pkg.sv
radio_ctrl_regs.sv
adc_capture_buf.sv
irq_ctrl.sv
led_pwm.sv
radio_core.sv
radio_core_props.sv
radio_checker.sv
tb_radio_core.sv

/* Bender.yml */
package:
  name: radio_core

sources:
  - radio_regs_pkg.sv
  - radio_periph_pkg.sv
  - radio_ctrl_regs.sv
  - adc_capture_buf.sv
  - irq_ctrl.sv
  - led_pwm.sv
  - radio_core.sv
  - target: test
    files:
      - radio_core_props.sv
      - radio_checker.sv
      - tb_radio_core.sv
